// ==== rtl/vmask_settings.svh ====
/*
 * Vector mask lane settings
 * Word, index and op code widths shared by the packages and the top level
 */
`ifndef VMASK_SETTINGS_SVH
`define VMASK_SETTINGS_SVH

// One mask word per lane, one result word out
`define VMASK_WORD_W 32

// Bit index and element offset, log2 of the word width
`define VMASK_IDX_W 5

// Pre-decoded mask op code
`define VMASK_OP_W 4

`endif

// ==== rtl/vmask_op_pkg.sv ====
/*
 * Mask operation codes
 * Sixteen pre-decoded ops of the vector mask lane
 */
`include "vmask_settings.svh"

package vmask_op_pkg;

  // Order is fixed, the encodings are what the decoder sends
  typedef enum logic [`VMASK_OP_W-1:0] {
    VMASK_AND,   // vs2 & vs1
    VMASK_NAND,  // ~(vs2 & vs1)
    VMASK_ANDN,  // vs2 & ~vs1
    VMASK_OR,    // vs2 | vs1
    VMASK_NOR,   // ~(vs2 | vs1)
    VMASK_ORN,   // vs2 | ~vs1
    VMASK_XOR,   // vs2 ^ vs1
    VMASK_XNOR,  // ~(vs2 ^ vs1)
    VMASK_POPC,  // Count of enabled bits
    VMASK_FIRST, // Index of first enabled bit, -1 if none
    VMASK_SBF,   // Set before first
    VMASK_SIF,   // Set including first
    VMASK_SOF,   // Set only first
    VMASK_IOTA,  // Prefix count, chained across words
    VMASK_ID,    // Element index
    VMASK_NOP
  } mask_op_t;

endpackage

// ==== rtl/vmask_data_pkg.sv ====
/*
 * Mask lane data types
 * Mask words, bit indices and population counts
 */
`include "vmask_settings.svh"

package vmask_data_pkg;

  // Mask source or result word
  typedef logic [`VMASK_WORD_W-1:0] mask_word_t;

  // Bit position inside one word
  typedef logic [`VMASK_IDX_W-1:0] bit_idx_t;

  // One extra bit so a full word of ones (32) still fits
  typedef logic [`VMASK_IDX_W:0] pop_cnt_t;

endpackage

// ==== rtl/vmask_lane_if.sv ====
/*
 * Lane interface
 * Request fields plus the shared popcounts and iota result between the lane blocks
 */
`timescale 1ns/1ps

interface vmask_lane_if import vmask_op_pkg::*, vmask_data_pkg::*; ();

  // Request, valid for one cycle
  logic       req;
  mask_op_t   op;
  mask_word_t vs1;
  mask_word_t vs2;
  mask_word_t mask;        // Element enables
  bit_idx_t   offset;      // Element position of bit 0 within the vector
  logic       chain_start; // First word of a vector

  // Counts from the one popcount tree in the mask unit
  pop_cnt_t   pop_below;
  pop_cnt_t   pop_full;

  // Iota value for the current request
  mask_word_t iota_res;

  // Request source
  modport lane (
    output req, op, vs1, vs2, mask, offset, chain_start
  );

  // Result path, owns the popcounts
  modport mask_unit (
    input  req, op, vs1, vs2, mask, offset, iota_res,
    output pop_below, pop_full
  );

  // Running prefix count
  modport iota (
    input  req, op, chain_start, pop_below, pop_full,
    output iota_res
  );

endinterface

// ==== rtl/first_set_encoder.sv ====
/*
 * First set bit encoder
 * Lowest set bit of the enabled word, with a found flag so index 0 is not "none"
 */
`timescale 1ns/1ps

module first_set_encoder import vmask_data_pkg::*; (
  input  mask_word_t word,
  output logic       found,
  output bit_idx_t   index
);

  // Priority from bit 0 upward, first hit wins
  always_comb begin
    found = 1'b0;
    index = '0; // Index reads 0 when nothing is set, found tells them apart
    for (int i = 0; i < $bits(mask_word_t); i++) begin
      if (word[i] && !found) begin
        found = 1'b1;
        index = bit_idx_t'(i);
      end
    end
  end

endmodule

// ==== rtl/popcount_tree.sv ====
/*
 * Popcount adder tree
 * Full count of a word and the count of its bits below the element offset
 */
`timescale 1ns/1ps

module popcount_tree import vmask_data_pkg::*; (
  input  mask_word_t word,
  input  bit_idx_t   offset,
  output pop_cnt_t   pop_full,
  output pop_cnt_t   pop_below
);

  mask_word_t below_mask;
  mask_word_t below_word;

  // Ones in one byte, pairs then nibbles
  function automatic logic [3:0] count_byte(input logic [7:0] b);
    logic [1:0] p0, p1, p2, p3;
    logic [2:0] n0, n1;
    p0 = {1'b0, b[0]} + {1'b0, b[1]};
    p1 = {1'b0, b[2]} + {1'b0, b[3]};
    p2 = {1'b0, b[4]} + {1'b0, b[5]};
    p3 = {1'b0, b[6]} + {1'b0, b[7]};
    n0 = {1'b0, p0} + {1'b0, p1};
    n1 = {1'b0, p2} + {1'b0, p3};
    return {1'b0, n0} + {1'b0, n1};
  endfunction

  // Four byte groups summed pairwise
  function automatic pop_cnt_t count_word(input mask_word_t w);
    logic [4:0] lo, hi;
    lo = {1'b0, count_byte(w[7:0])}   + {1'b0, count_byte(w[15:8])};
    hi = {1'b0, count_byte(w[23:16])} + {1'b0, count_byte(w[31:24])};
    return {1'b0, lo} + {1'b0, hi};
  endfunction

  // Bits strictly below offset, empty when offset is 0
  assign below_mask = ~({$bits(mask_word_t){1'b1}} << offset);
  assign below_word = word & below_mask;

  assign pop_full  = count_word(word);
  assign pop_below = count_word(below_word);

endmodule

// ==== rtl/iota_accum.sv ====
/*
 * Iota accumulator
 * Running enabled-bit count over the mask words of one vector
 */
`timescale 1ns/1ps

module iota_accum import vmask_op_pkg::*, vmask_data_pkg::*; (
  input logic CLK,
  input logic nRST,
  vmask_lane_if.iota bus
);

  mask_word_t accum; // Enabled bits seen in earlier words of this vector
  mask_word_t base;
  logic       iota_req;

  assign iota_req = bus.req && (bus.op == VMASK_IOTA);

  // New vector starts counting from zero
  assign base = bus.chain_start ? '0 : accum;

  // Prefix value for this word's offset
  assign bus.iota_res = base + mask_word_t'(bus.pop_below);

  // Only IOTA moves the count, other ops in between leave it alone
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      accum <= '0;
    end else if (iota_req) begin
      accum <= base + mask_word_t'(bus.pop_full); // Carry the whole word into the next one
    end
  end

endmodule

// ==== rtl/mask_unit.sv ====
/*
 * Mask unit
 * Selects the result for every mask op and registers it with the request strobe
 */
`timescale 1ns/1ps

module mask_unit import vmask_op_pkg::*, vmask_data_pkg::*; (
  input  logic       CLK,
  input  logic       nRST,
  vmask_lane_if.mask_unit bus,
  output logic       result_valid,
  output mask_word_t result
);

  mask_word_t enabled;     // vs2 gated by the element enables
  mask_word_t first_res;
  mask_word_t sbf_res;
  mask_word_t sif_res;
  mask_word_t sof_res;
  mask_word_t next_result;
  logic       found;       // Some enabled bit is set
  bit_idx_t   first_idx;

  assign enabled = bus.vs2 & bus.mask;

  first_set_encoder u_first (
    .word  (enabled),
    .found (found),
    .index (first_idx)
  );

  // Counts go out on the interface so the iota block reuses them
  popcount_tree u_popc (
    .word      (enabled),
    .offset    (bus.offset),
    .pop_full  (bus.pop_full),
    .pop_below (bus.pop_below)
  );

  // Each first-bit result has its own no-bit-set value
  assign first_res = found ? mask_word_t'(first_idx) : '1;                       // -1 when none
  assign sbf_res   = found ? ~(mask_word_t'('1) << first_idx) : '1;              // f = 0 gives 0
  assign sif_res   = found ? ~((mask_word_t'('1) << first_idx) << 1) : '1;       // f = 31 gives all ones
  assign sof_res   = found ? (mask_word_t'(1) << first_idx) : '0;

  always_comb begin
    case (bus.op)
      // Logicals see vs2 and vs1 only and ignore the mask
      VMASK_AND   : next_result =   bus.vs2 &  bus.vs1;
      VMASK_NAND  : next_result = ~(bus.vs2 &  bus.vs1);
      VMASK_ANDN  : next_result =   bus.vs2 & ~bus.vs1;
      VMASK_OR    : next_result =   bus.vs2 |  bus.vs1;
      VMASK_NOR   : next_result = ~(bus.vs2 |  bus.vs1);
      VMASK_ORN   : next_result =   bus.vs2 | ~bus.vs1;
      VMASK_XOR   : next_result =   bus.vs2 ^  bus.vs1;
      VMASK_XNOR  : next_result = ~(bus.vs2 ^  bus.vs1);
      VMASK_POPC  : next_result = mask_word_t'(bus.pop_full);
      VMASK_FIRST : next_result = first_res;
      VMASK_SBF   : next_result = sbf_res;
      VMASK_SIF   : next_result = sif_res;
      VMASK_SOF   : next_result = sof_res;
      VMASK_IOTA  : next_result = bus.iota_res; // Base chosen in the accumulator
      VMASK_ID    : next_result = mask_word_t'(bus.offset);
      default     : next_result = '0;           // NOP
    endcase
  end

  // Output stage one cycle after the request
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= bus.req;
      if (bus.req) begin
        result <= next_result; // Hold the last result over idle cycles
      end
    end
  end

endmodule

// ==== rtl/vmask_lane_top.sv ====
/*
 * Vector mask lane
 * One request in, one registered result out a cycle later
 */
`timescale 1ns/1ps

`include "vmask_settings.svh"

module vmask_lane_top import vmask_op_pkg::*; (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    in_valid,
  input  logic [`VMASK_OP_W-1:0]  in_op,
  input  logic [`VMASK_WORD_W-1:0] in_vs1,
  input  logic [`VMASK_WORD_W-1:0] in_vs2,
  input  logic [`VMASK_WORD_W-1:0] in_mask,
  input  logic [`VMASK_IDX_W-1:0] in_offset,
  input  logic                    in_chain_start,
  output logic                    out_valid,
  output logic [`VMASK_WORD_W-1:0] out_result
);

  vmask_lane_if bus ();

  // Request fields onto the lane bus
  assign bus.req         = in_valid;
  assign bus.op          = mask_op_t'(in_op); // Already decoded upstream
  assign bus.vs1         = in_vs1;
  assign bus.vs2         = in_vs2;
  assign bus.mask        = in_mask;
  assign bus.offset      = in_offset;
  assign bus.chain_start = in_chain_start;

  // Result path and output register
  mask_unit u_mask_unit (
    .CLK          (CLK),
    .nRST         (nRST),
    .bus          (bus.mask_unit),
    .result_valid (out_valid),
    .result       (out_result)
  );

  // Iota running count, feeds the mask unit through the bus
  iota_accum u_iota_accum (
    .CLK  (CLK),
    .nRST (nRST),
    .bus  (bus.iota)
  );

endmodule

// ==== tb/vmask_model_pkg.sv ====
/*
 * Mask lane reference model
 * Bit-by-bit result rules, its own iota accumulator and the LFSR random source
 */
package vmask_model_pkg;

  import vmask_op_pkg::*;
  import vmask_data_pkg::*;

  // x^32 + x^22 + x^2 + x + 1, right-shifting Galois form
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  mask_word_t model_acc; // Enabled bits of earlier words in the current vector

  // One LFSR step, the caller takes bit 0 before stepping
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ LFSR_TAPS;
    end
    return s >> 1;
  endfunction

  // Set bits at positions below limit
  function automatic int count_below(input mask_word_t w, input int limit);
    int n;
    n = 0;
    for (int i = 0; i < $bits(mask_word_t); i++) begin
      if (i < limit && w[i]) n++;
    end
    return n;
  endfunction

  // Lowest set position, -1 when the word is empty
  function automatic int first_index(input mask_word_t w);
    for (int i = 0; i < $bits(mask_word_t); i++) begin
      if (w[i]) return i;
    end
    return -1;
  endfunction

  task automatic model_reset();
    model_acc = '0;
  endtask

  // Expected result of one request, moves the accumulator on IOTA
  task automatic predict(input mask_op_t op, input mask_word_t vs1, input mask_word_t vs2,
                         input mask_word_t mask, input bit_idx_t offset,
                         input logic chain_start, output mask_word_t res);
    mask_word_t en;
    mask_word_t base;
    int         f;
    en  = vs2 & mask; // Enabled word
    f   = first_index(en);
    res = '0;
    case (op)
      VMASK_AND   : res = vs2 & vs1;
      VMASK_NAND  : res = ~(vs2 & vs1);
      VMASK_ANDN  : res = vs2 & ~vs1;
      VMASK_OR    : res = vs2 | vs1;
      VMASK_NOR   : res = ~(vs2 | vs1);
      VMASK_ORN   : res = vs2 | ~vs1;
      VMASK_XOR   : res = vs2 ^ vs1;
      VMASK_XNOR  : res = ~(vs2 ^ vs1);
      VMASK_POPC  : res = mask_word_t'(count_below(en, $bits(mask_word_t)));
      VMASK_FIRST : res = (f < 0) ? '1 : mask_word_t'(f);
      VMASK_SBF   : for (int i = 0; i < $bits(mask_word_t); i++) res[i] = (f < 0) || (i < f);
      VMASK_SIF   : for (int i = 0; i < $bits(mask_word_t); i++) res[i] = (f < 0) || (i <= f);
      VMASK_SOF   : for (int i = 0; i < $bits(mask_word_t); i++) res[i] = (i == f);
      VMASK_IOTA  : begin
        base      = chain_start ? '0 : model_acc; // Restart at a new vector
        res       = base + mask_word_t'(count_below(en, int'(offset)));
        model_acc = base + mask_word_t'(count_below(en, $bits(mask_word_t)));
      end
      VMASK_ID    : res = mask_word_t'(offset);
      default     : res = '0; // NOP
    endcase
  endtask

endpackage

// ==== tb/tb_vmask_lane.sv ====
/*
 * Mask lane testbench
 * Random requests from a fixed seed, each result checked against the model
 */
`timescale 1ns/1ps

module tb_vmask_lane import vmask_op_pkg::*, vmask_data_pkg::*, vmask_model_pkg::*; ();

  localparam int RESET_CYCLES   = 4;
  localparam int NUM_CYCLES     = 2000;
  localparam int DRAIN_CYCLES   = 4;
  localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100; // Reset, drain and some slack

  logic       CLK;
  logic       nRST;
  logic       in_valid;
  logic [3:0] in_op;
  mask_word_t in_vs1;
  mask_word_t in_vs2;
  mask_word_t in_mask;
  bit_idx_t   in_offset;
  logic       in_chain_start;
  logic       out_valid;
  mask_word_t out_result;

  logic [31:0] lfsr;     // Random source state
  int          cyc;      // Rising edges seen so far
  mask_word_t  exp_q[$]; // Expected results in request order
  int          due_q[$]; // Edge at which each result must be seen

  vmask_lane_top uut (
    .CLK            (CLK),
    .nRST           (nRST),
    .in_valid       (in_valid),
    .in_op          (in_op),
    .in_vs1         (in_vs1),
    .in_vs2         (in_vs2),
    .in_mask        (in_mask),
    .in_offset      (in_offset),
    .in_chain_start (in_chain_start),
    .out_valid      (out_valid),
    .out_result     (out_result)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK; // 20 ns period
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("mismatch at %0t: %s got %h expected %h",
                                  $time, name, got, expected));
    end
  endtask

  // n random bits, one LFSR step per bit
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Random word, a fixed special word, or a single set bit
  task automatic draw_word(input mask_word_t special, output mask_word_t w);
    logic [31:0] r;
    draw_bits(2, r);
    case (r[1:0])
      2'd2    : w = special;
      2'd3    : begin
        draw_bits(5, r);
        w = mask_word_t'(1) << r[4:0]; // Bit 0 included, tests index 0 against none
      end
      default : draw_bits(32, w);
    endcase
  endtask

  // All fields random every cycle, idle ones must leave no trace
  task automatic drive_cycle();
    logic [31:0] r;
    mask_word_t  expected;
    draw_bits(2, r);
    in_valid = (r[1:0] != 2'b00); // About 3 in 4 cycles busy
    draw_bits(4, r);
    in_op = r[3:0];
    draw_bits(32, r);
    in_vs1 = r;
    draw_word('0, in_vs2);  // Sometimes empty
    draw_word('1, in_mask); // Sometimes fully enabled
    draw_bits(5, r);
    in_offset = r[4:0];
    draw_bits(3, r);
    in_chain_start = (r[2:0] == 3'b000); // IOTA chains of about 8 words
    if (in_valid) begin
      predict(mask_op_t'(in_op), in_vs1, in_vs2, in_mask, in_offset, in_chain_start,
              expected);
      exp_q.push_back(expected);
      due_q.push_back(cyc + 2); // Captured at the next edge, seen on the one after
    end
  endtask

  // Scoreboard and timeout on every rising edge
  initial begin
    mask_word_t exp_word;
    int         due;
    cyc = 0;
    forever begin
      @(posedge CLK);
      cyc++;
      if (cyc >= TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("Timeout after %0d cycles with %0d results still missing",
                                    cyc, exp_q.size()));
      end
      if (!nRST) check_value("out_valid", {31'b0, out_valid}, 32'd0);
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          stop_with_failure($sformatf("Unexpected output at %0t with no request pending",
                                      $time));
        end
        exp_word = exp_q.pop_front();
        due      = due_q.pop_front();
        check_value("out_result", out_result, exp_word);
        check_value("result cycle", cyc, due); // Exactly one cycle of latency
      end else if (due_q.size() != 0 && due_q[0] == cyc) begin
        stop_with_failure($sformatf("No output at %0t for a request one cycle earlier",
                                    $time));
      end
    end
  end

  initial begin
    lfsr           = 32'hc4962f10;
    nRST           = 1'b1;
    in_valid       = 1'b0;
    in_op          = '0;
    in_vs1         = '0;
    in_vs2         = '0;
    in_mask        = '0;
    in_offset      = '0;
    in_chain_start = 1'b0;
    model_reset();
    #5 nRST = 1'b0; // Clean falling edge before the first clock
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
    for (int n = 0; n < NUM_CYCLES; n++) begin
      drive_cycle();
      @(negedge CLK);
    end
    in_valid = 1'b0;
    while (exp_q.size() != 0) @(posedge CLK);
    repeat (DRAIN_CYCLES) @(posedge CLK); // Stray outputs still caught here
    $display("No errors");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/vmask_op_pkg.sv
rtl/vmask_data_pkg.sv
rtl/vmask_lane_if.sv
rtl/first_set_encoder.sv
rtl/popcount_tree.sv
rtl/iota_accum.sv
rtl/mask_unit.sv
rtl/vmask_lane_top.sv
tb/vmask_model_pkg.sv
tb/tb_vmask_lane.sv

// ==== Bender.yml ====
package:
  name: vmask_lane

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/vmask_op_pkg.sv
      - rtl/vmask_data_pkg.sv
      - rtl/vmask_lane_if.sv
      - rtl/first_set_encoder.sv
      - rtl/popcount_tree.sv
      - rtl/iota_accum.sv
      - rtl/mask_unit.sv
      - rtl/vmask_lane_top.sv
  - target: test
    files:
      - tb/vmask_model_pkg.sv
      - tb/tb_vmask_lane.sv
